/* source/spi_bus_pkg.sv */
// AXI-lite channel and byte stream types, shared by every module of the SPI controller.
package spi_bus_pkg;

    localparam int DATA_W      = 8;  // spi byte width.
    localparam int AXIL_DATA_W = 32;

    // write address channel.
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic                   valid;
        logic [AXIL_DATA_W-1:0] data;
    } axil_w_t;

    // response is always OKAY, so only valid travels.
    typedef struct packed {
        logic valid;
    } axil_b_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic                   valid;
        logic [AXIL_DATA_W-1:0] data;
    } axil_r_t;

    // ready runs back on its own wire.
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } byte_stream_t;

endpackage

/* source/spi_reg_pkg.sv */
// Register map of the SPI controller: indexes, field layouts, the bus word view and reset values.
package spi_reg_pkg;

    localparam int REG_NUM = 8;

    localparam logic [2:0] CONTROL_REG = 3'd0;
    localparam logic [2:0] STATUS_REG  = 3'd1;
    localparam logic [2:0] SLAVE_REG   = 3'd2;
    localparam logic [2:0] DIVIDER_REG = 3'd3;
    localparam logic [2:0] WAIT_REG    = 3'd4;
    localparam logic [2:0] TX_DATA_REG = 3'd5;
    localparam logic [2:0] RX_DATA_REG = 3'd6;
    localparam logic [2:0] PARAM_REG   = 3'd7;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        cpha;
        logic        cpol;
        logic        soft_reset;  // bit 0.
    } control_t;

    typedef struct packed {
        logic [27:0] rsvd;
        logic        tx_full;
        logic        rx_full;
        logic        tx_empty;
        logic        rx_empty;
    } status_t;

    typedef struct packed {
        logic [7:0]  reg_num;
        logic [15:0] fifo_depth;
        logic [7:0]  data_width;
    } param_t;

    // data registers use only the low byte.
    typedef struct packed {
        logic [spi_bus_pkg::AXIL_DATA_W-spi_bus_pkg::DATA_W-1:0] rsvd;
        logic [spi_bus_pkg::DATA_W-1:0]                          data;
    } low_byte_t;

    // one bus word, read according to the register it addresses.
    typedef union packed {
        logic [spi_bus_pkg::AXIL_DATA_W-1:0] raw;
        control_t                            control;
        status_t                             status;
        param_t                              param;
        low_byte_t                           lo;
    } spi_reg_word_u;

    typedef struct packed {
        logic                           cpol;
        logic                           cpha;
        logic [spi_bus_pkg::DATA_W-1:0] slave;
        logic [spi_bus_pkg::DATA_W-1:0] divider;
        logic [spi_bus_pkg::DATA_W-1:0] wait_time;
    } spi_cfg_t;

    localparam control_t CONTROL_INIT = '{
        rsvd:       '0,
        cpha:       1'b0,
        cpol:       1'b0,
        soft_reset: 1'b0
    };

endpackage

/* source/spi_byte_fifo.sv */
// First-word-fall-through byte FIFO with valid/ready on both sides, used for transmit and receive.
`timescale 1ns/1ns

module spi_byte_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      flush_i,
    input  spi_bus_pkg::byte_stream_t in_i,
    output logic                      in_ready_o,
    output spi_bus_pkg::byte_stream_t out_o,
    input  logic                      out_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [spi_bus_pkg::DATA_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]               wr_ptr_q;
    logic [PTR_W-1:0]               rd_ptr_q;
    logic [PTR_W:0]                 count_q;
    logic                           push;
    logic                           pop;

    assign in_ready_o = count_q != (PTR_W + 1)'(DEPTH);
    assign out_o.valid = count_q != '0;
    assign out_o.data  = mem_q[rd_ptr_q];

    assign push = in_i.valid & in_ready_o;
    assign pop  = out_o.valid & out_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is a power of two.
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_i.data;
        end
    end

endmodule

/* source/spi_shift_engine.sv */
// SPI master shift engine: one byte per chip select cycle, with CPOL/CPHA, SCLK divider and idle gap.
`timescale 1ns/1ns

module spi_shift_engine #(
    parameter int SLAVE_NUM = 1
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      flush_i,
    input  spi_reg_pkg::spi_cfg_t     cfg_i,
    input  spi_bus_pkg::byte_stream_t tx_i,
    output logic                      tx_ready_o,
    output spi_bus_pkg::byte_stream_t rx_o,
    input  logic                      rx_ready_i,
    output logic                      sclk_o,
    output logic                      mosi_o,
    output logic [SLAVE_NUM-1:0]      cs_n_o,
    input  logic                      miso_i
);

    localparam int DW     = spi_bus_pkg::DATA_W;
    localparam int EDGE_W = $clog2(2 * DW);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_WAIT
    } state_t;

    state_t               state_q;
    logic [DW-1:0]        shift_q;
    logic [DW-1:0]        div_cnt_q;
    logic [DW-1:0]        wait_cnt_q;
    logic [EDGE_W-1:0]    edge_cnt_q;
    logic                 sclk_q;
    logic                 miso_q;
    logic                 rx_valid_q;
    logic [SLAVE_NUM-1:0] cs_n_q;
    logic                 tick;
    logic                 sample;
    logic                 last;
    logic                 do_shift;
    logic                 shift_in;
    logic                 wait_done;
    logic                 start;

    assign tick = (state_q == ST_SHIFT) && (div_cnt_q == cfg_i.divider);
    // even edge count means a leading edge. cpha moves sampling to the trailing one.
    assign sample    = ~edge_cnt_q[0] ^ cfg_i.cpha;
    assign last      = edge_cnt_q == EDGE_W'(2 * DW - 1);
    assign shift_in  = sample ? miso_i : miso_q;
    // cpha=1 skips the first leading edge and takes its final bit straight from miso.
    assign do_shift  = sample ? last : (edge_cnt_q != '0);
    assign wait_done = wait_cnt_q == cfg_i.wait_time;

    // no new byte unless the receive side has room.
    assign tx_ready_o = rx_ready_i && ((state_q == ST_IDLE) || ((state_q == ST_WAIT) && wait_done));
    assign start      = tx_ready_o && tx_i.valid;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            shift_q    <= '0;
            div_cnt_q  <= '0;
            wait_cnt_q <= '0;
            edge_cnt_q <= '0;
            sclk_q     <= 1'b0;
            miso_q     <= 1'b0;
            rx_valid_q <= 1'b0;
            cs_n_q     <= '1;
        end else if (flush_i) begin
            state_q    <= ST_IDLE;
            sclk_q     <= cfg_i.cpol;
            rx_valid_q <= 1'b0;
            cs_n_q     <= '1;
        end else begin
            if (rx_valid_q && rx_ready_i) rx_valid_q <= 1'b0;
            if (start) begin
                state_q    <= ST_SHIFT;
                shift_q    <= tx_i.data;
                div_cnt_q  <= '0;
                edge_cnt_q <= '0;
                sclk_q     <= cfg_i.cpol;
                for (int i = 0; i < SLAVE_NUM; i++) begin
                    cs_n_q[i] <= cfg_i.slave != DW'(i);  // one-hot low.
                end
            end else begin
                case (state_q)
                    ST_IDLE: sclk_q <= cfg_i.cpol;
                    ST_SHIFT: begin
                        if (tick) begin
                            div_cnt_q  <= '0;
                            sclk_q     <= ~sclk_q;
                            edge_cnt_q <= edge_cnt_q + 1'b1;
                            if (sample) miso_q <= miso_i;
                            if (do_shift) shift_q <= {shift_q[DW-2:0], shift_in};
                            if (last) begin
                                state_q    <= ST_WAIT;
                                wait_cnt_q <= '0;
                                cs_n_q     <= '1;
                                rx_valid_q <= 1'b1;  // shift_q now holds the rx byte.
                            end
                        end else begin
                            div_cnt_q <= div_cnt_q + 1'b1;
                        end
                    end
                    ST_WAIT: begin
                        if (!wait_done) begin
                            wait_cnt_q <= wait_cnt_q + 1'b1;
                        end else if (!rx_valid_q || rx_ready_i) begin
                            state_q <= ST_IDLE;
                        end
                    end
                    default: state_q <= ST_IDLE;
                endcase
            end
        end
    end

    assign sclk_o     = sclk_q;
    assign mosi_o     = shift_q[DW-1];  // msb first.
    assign cs_n_o     = cs_n_q;
    assign rx_o.valid = rx_valid_q;
    assign rx_o.data  = shift_q;

endmodule

/* source/axil_spi_regs.sv */
// AXI-lite slave with the register file; drives SPI configuration and the FIFO push/pop strobes.
`timescale 1ns/1ns

module axil_spi_regs #(
    parameter int FIFO_DEPTH  = 16,
    parameter int SLAVE_NUM   = 1,
    parameter int AXIL_ADDR_W = 32
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  spi_bus_pkg::axil_aw_t     aw_i,
    output logic                      aw_ready_o,
    input  spi_bus_pkg::axil_w_t      w_i,
    output logic                      w_ready_o,
    output spi_bus_pkg::axil_b_t      b_o,
    input  logic                      b_ready_i,
    input  spi_bus_pkg::axil_ar_t     ar_i,
    output logic                      ar_ready_o,
    output spi_bus_pkg::axil_r_t      r_o,
    input  logic                      r_ready_i,
    output spi_reg_pkg::spi_cfg_t     cfg_o,
    output logic                      soft_reset_o,
    output spi_bus_pkg::byte_stream_t tx_push_o,
    input  logic                      tx_ready_i,
    input  spi_bus_pkg::byte_stream_t rx_head_i,
    output logic                      rx_pop_o,
    input  logic                      tx_head_valid_i,
    input  logic                      rx_ready_i
);

    spi_reg_pkg::control_t                 control_q;
    logic [spi_bus_pkg::DATA_W-1:0]        slave_q;
    logic [spi_bus_pkg::DATA_W-1:0]        divider_q;
    logic [spi_bus_pkg::DATA_W-1:0]        wait_q;
    logic                                  alive_q;
    logic                                  b_valid_q;
    logic                                  r_valid_q;
    logic [spi_bus_pkg::AXIL_DATA_W-1:0]   r_data_q;
    logic                                  wr_ok;
    logic                                  rd_ok;
    logic [AXIL_ADDR_W-1:0]                waddr;
    logic [AXIL_ADDR_W-1:0]                raddr;
    logic [2:0]                            widx;
    logic [2:0]                            ridx;
    spi_reg_pkg::spi_reg_word_u            wword;
    spi_reg_pkg::spi_reg_word_u            rword;

    // one transfer in flight at a time, writes win a tie.
    assign wr_ok = alive_q & aw_i.valid & w_i.valid & ~b_valid_q & ~r_valid_q;
    assign rd_ok = alive_q & ar_i.valid & ~b_valid_q & ~r_valid_q & ~wr_ok;

    assign aw_ready_o = wr_ok;
    assign w_ready_o  = wr_ok;
    assign ar_ready_o = rd_ok;

    assign waddr = aw_i.addr[AXIL_ADDR_W-1:0];
    assign raddr = ar_i.addr[AXIL_ADDR_W-1:0];
    assign widx  = waddr[4:2];
    assign ridx  = raddr[4:2];
    assign wword = spi_reg_pkg::spi_reg_word_u'(w_i.data);

    assign tx_push_o.valid = wr_ok && (widx == spi_reg_pkg::TX_DATA_REG);
    assign tx_push_o.data  = wword.lo.data;
    assign rx_pop_o        = rd_ok && (ridx == spi_reg_pkg::RX_DATA_REG) && rx_head_i.valid;

    always_comb begin
        rword.raw = '0;
        case (ridx)
            spi_reg_pkg::CONTROL_REG: rword.control = control_q;
            spi_reg_pkg::STATUS_REG: begin
                rword.status.rx_empty = ~rx_head_i.valid;
                rword.status.tx_empty = ~tx_head_valid_i;
                rword.status.rx_full  = ~rx_ready_i;
                rword.status.tx_full  = ~tx_ready_i;
            end
            spi_reg_pkg::SLAVE_REG:   rword.lo.data = slave_q;
            spi_reg_pkg::DIVIDER_REG: rword.lo.data = divider_q;
            spi_reg_pkg::WAIT_REG:    rword.lo.data = wait_q;
            spi_reg_pkg::RX_DATA_REG: begin
                if (rx_head_i.valid) begin
                    rword.lo.data = rx_head_i.data;  // empty fifo reads 0.
                end
            end
            spi_reg_pkg::PARAM_REG: begin
                rword.param.data_width = 8'(spi_bus_pkg::DATA_W);
                rword.param.fifo_depth = 16'(FIFO_DEPTH);
                rword.param.reg_num    = 8'(spi_reg_pkg::REG_NUM);
            end
            default: rword.raw = '0;  // tx data is write only.
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            control_q <= spi_reg_pkg::CONTROL_INIT;
            slave_q   <= '0;
            divider_q <= '0;
            wait_q    <= '0;
        end else if (wr_ok) begin
            case (widx)
                spi_reg_pkg::CONTROL_REG: begin
                    control_q.soft_reset <= wword.control.soft_reset;
                    control_q.cpol       <= wword.control.cpol;
                    control_q.cpha       <= wword.control.cpha;
                end
                spi_reg_pkg::SLAVE_REG: begin
                    if (wword.lo.data < SLAVE_NUM) begin
                        slave_q <= wword.lo.data;  // out of range select ignored.
                    end
                end
                spi_reg_pkg::DIVIDER_REG: divider_q <= wword.lo.data;
                spi_reg_pkg::WAIT_REG:    wait_q    <= wword.lo.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alive_q   <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            alive_q <= 1'b1;
            if (wr_ok) begin
                b_valid_q <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_q <= 1'b0;
            end
            if (rd_ok) begin
                r_valid_q <= 1'b1;
            end else if (r_ready_i) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_ok) begin
            r_data_q <= rword.raw;
        end
    end

    assign b_o.valid = b_valid_q;
    assign r_o.valid = r_valid_q;
    assign r_o.data  = r_data_q;

    assign soft_reset_o    = control_q.soft_reset;
    assign cfg_o.cpol      = control_q.cpol;
    assign cfg_o.cpha      = control_q.cpha;
    assign cfg_o.slave     = slave_q;
    assign cfg_o.divider   = divider_q;
    assign cfg_o.wait_time = wait_q;

endmodule

/* source/axil_spi.sv */
// Top level of the AXI-lite SPI master; ties the register file, both byte FIFOs and the engine.
`timescale 1ns/1ns

module axil_spi #(
    parameter int FIFO_DEPTH  = 16,
    parameter int SLAVE_NUM   = 1,
    parameter int AXIL_ADDR_W = 32
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  spi_bus_pkg::axil_aw_t aw_i,
    output logic                  aw_ready_o,
    input  spi_bus_pkg::axil_w_t  w_i,
    output logic                  w_ready_o,
    output spi_bus_pkg::axil_b_t  b_o,
    input  logic                  b_ready_i,
    input  spi_bus_pkg::axil_ar_t ar_i,
    output logic                  ar_ready_o,
    output spi_bus_pkg::axil_r_t  r_o,
    input  logic                  r_ready_i,
    output logic                  sclk_o,
    output logic                  mosi_o,
    output logic [SLAVE_NUM-1:0]  cs_n_o,
    input  logic                  miso_i
);

    spi_reg_pkg::spi_cfg_t     cfg;
    logic                      soft_reset;
    spi_bus_pkg::byte_stream_t tx_push;
    logic                      tx_push_ready;
    spi_bus_pkg::byte_stream_t tx_head;
    logic                      tx_head_ready;
    spi_bus_pkg::byte_stream_t rx_push;
    logic                      rx_push_ready;
    spi_bus_pkg::byte_stream_t rx_head;
    logic                      rx_pop;

    axil_spi_regs #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .SLAVE_NUM  (SLAVE_NUM),
        .AXIL_ADDR_W(AXIL_ADDR_W)
    ) u_regs (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .aw_i           (aw_i),
        .aw_ready_o     (aw_ready_o),
        .w_i            (w_i),
        .w_ready_o      (w_ready_o),
        .b_o            (b_o),
        .b_ready_i      (b_ready_i),
        .ar_i           (ar_i),
        .ar_ready_o     (ar_ready_o),
        .r_o            (r_o),
        .r_ready_i      (r_ready_i),
        .cfg_o          (cfg),
        .soft_reset_o   (soft_reset),
        .tx_push_o      (tx_push),
        .tx_ready_i     (tx_push_ready),
        .rx_head_i      (rx_head),
        .rx_pop_o       (rx_pop),
        .tx_head_valid_i(tx_head.valid),
        .rx_ready_i     (rx_push_ready)
    );

    spi_byte_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_tx_fifo (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .flush_i    (soft_reset),
        .in_i       (tx_push),
        .in_ready_o (tx_push_ready),
        .out_o      (tx_head),
        .out_ready_i(tx_head_ready)
    );

    spi_shift_engine #(
        .SLAVE_NUM(SLAVE_NUM)
    ) u_engine (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .flush_i   (soft_reset),
        .cfg_i     (cfg),
        .tx_i      (tx_head),
        .tx_ready_o(tx_head_ready),
        .rx_o      (rx_push),
        .rx_ready_i(rx_push_ready),
        .sclk_o    (sclk_o),
        .mosi_o    (mosi_o),
        .cs_n_o    (cs_n_o),
        .miso_i    (miso_i)
    );

    spi_byte_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_rx_fifo (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .flush_i    (soft_reset),
        .in_i       (rx_push),
        .in_ready_o (rx_push_ready),
        .out_o      (rx_head),
        .out_ready_i(rx_pop)
    );

endmodule

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source; instantiate once in the testbench top to drive clk and arst_n.
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;  // 10 ns period.
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;  // released away from the active edge.
    end

endmodule

/* tb/axil_spi_tb.sv */
// Table-driven testbench for the AXI-lite SPI master; run as top module with MISO looped to MOSI.
`timescale 1ns/1ns

module axil_spi_tb;

    localparam int DW         = spi_bus_pkg::DATA_W;
    localparam int FIFO_DEPTH = 4;
    localparam int SLAVE_NUM  = 2;
    localparam int ROWS       = 6;
    localparam int BURST      = 6;
    localparam int BIG_DIV    = 15;
    localparam int TIMEOUT    = (ROWS + BURST) * 16 * (BIG_DIV + 1) * 2 + 1000;

    typedef struct packed {
        logic          cpol;
        logic          cpha;
        logic [DW-1:0] divider;
        logic [DW-1:0] wait_time;
        logic [DW-1:0] slave;
        logic [DW-1:0] tx;
    } stim_row_t;

    logic                      clk;
    logic                      arst_n;
    spi_bus_pkg::axil_aw_t     aw;
    spi_bus_pkg::axil_w_t      w_ch;
    spi_bus_pkg::axil_b_t      b;
    spi_bus_pkg::axil_ar_t     ar;
    spi_bus_pkg::axil_r_t      r;
    logic                      aw_ready;
    logic                      w_ready;
    logic                      ar_ready;
    logic                      b_ready;
    logic                      r_ready;
    logic                      sclk;
    logic                      mosi;
    logic                      miso;
    logic [SLAVE_NUM-1:0]      cs_n;
    integer                    seed = 32'hf2384f99;
    int                        err_cnt = 0;
    int                        cycle_cnt = 0;
    stim_row_t                 cur_row = '0;
    logic                      mon_on = 1'b0;
    logic                      prev_on = 1'b0;
    logic                      prev_sclk = 1'b0;
    logic                      prev_mosi = 1'b0;
    logic                      prev_cs_low = 1'b0;
    logic [DW-1:0]             mon_bits = '0;
    logic [DW-1:0]             mon_cnt = '0;

    // tx column is filled from $random before the loop.
    stim_row_t stim_table [ROWS] = '{
        '{1'b0, 1'b0, 8'd1, 8'd2, 8'd0, 8'h00},
        '{1'b0, 1'b1, 8'd0, 8'd0, 8'd1, 8'h00},
        '{1'b1, 1'b0, 8'd2, 8'd1, 8'd0, 8'h00},
        '{1'b1, 1'b1, 8'd3, 8'd3, 8'd1, 8'h00},
        '{1'b0, 1'b0, 8'd0, 8'd1, 8'd1, 8'h00},
        '{1'b1, 1'b1, 8'd1, 8'd0, 8'd0, 8'h00}
    };

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .arst_n_o(arst_n)
    );

    assign miso = mosi;  // loopback.

    axil_spi #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .SLAVE_NUM  (SLAVE_NUM),
        .AXIL_ADDR_W(32)
    ) UUT (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .aw_i      (aw),
        .aw_ready_o(aw_ready),
        .w_i       (w_ch),
        .w_ready_o (w_ready),
        .b_o       (b),
        .b_ready_i (b_ready),
        .ar_i      (ar),
        .ar_ready_o(ar_ready),
        .r_o       (r),
        .r_ready_i (r_ready),
        .sclk_o    (sclk),
        .mosi_o    (mosi),
        .cs_n_o    (cs_n),
        .miso_i    (miso)
    );

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_status(input string name, input spi_reg_pkg::status_t got,
                                input spi_reg_pkg::status_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input spi_reg_pkg::spi_reg_word_u got,
                              input spi_reg_pkg::spi_reg_word_u exp);
        if (got.raw !== exp.raw) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got.raw, exp.raw);
            err_cnt++;
            stop_run();
        end
    endtask

    task automatic check_select(input string name, input logic [SLAVE_NUM-1:0] got,
                                input logic [SLAVE_NUM-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
            stop_run();
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
            stop_run();
        end
    endtask

    // address and data together, then hold b_ready for one cycle.
    task automatic bus_write(input logic [2:0] idx, input logic [31:0] data);
        @(negedge clk);
        aw.valid   = 1'b1;
        aw.addr    = {27'd0, idx, 2'b00};
        w_ch.valid = 1'b1;
        w_ch.data  = data;
        #1;  // readies follow the valids combinationally.
        while (!aw_ready) begin
            @(negedge clk);
            #1;
        end
        check_pin("w_ready_o", w_ready, 1'b1);
        @(negedge clk);
        aw.valid   = 1'b0;
        w_ch.valid = 1'b0;
        check_pin("b_o.valid", b.valid, 1'b1);
        b_ready    = 1'b1;
        @(negedge clk);
        b_ready    = 1'b0;
    endtask

    task automatic bus_read(input logic [2:0] idx, output spi_reg_pkg::spi_reg_word_u word);
        @(negedge clk);
        ar.valid = 1'b1;
        ar.addr  = {27'd0, idx, 2'b00};
        #1;
        while (!ar_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ar.valid = 1'b0;
        check_pin("r_o.valid", r.valid, 1'b1);
        word.raw = r.data;
        r_ready  = 1'b1;
        @(negedge clk);
        r_ready  = 1'b0;
    endtask

    task automatic set_mode(input stim_row_t row);
        spi_reg_pkg::spi_reg_word_u ctrl;
        ctrl.raw          = '0;
        ctrl.control.cpol = row.cpol;
        ctrl.control.cpha = row.cpha;
        bus_write(spi_reg_pkg::SLAVE_REG, {24'd0, row.slave});
        bus_write(spi_reg_pkg::DIVIDER_REG, {24'd0, row.divider});
        bus_write(spi_reg_pkg::WAIT_REG, {24'd0, row.wait_time});
        bus_write(spi_reg_pkg::CONTROL_REG, ctrl.raw);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT never finished the tests", cycle_cnt);
            stop_run();
        end
    end

    // pin monitor. mosi is taken as it was just before the sampling edge.
    always @(negedge clk) begin
        if (mon_on && !prev_on) begin
            mon_bits = '0;
            mon_cnt  = '0;
        end
        if (mon_on) begin
            if (cs_n != '1) begin
                check_select("cs_n_o", cs_n, ~(SLAVE_NUM'(1) << cur_row.slave));
            end else begin
                check_pin("sclk_o", sclk, cur_row.cpol);
            end
            if (prev_cs_low && (sclk != prev_sclk) &&
                (sclk == (cur_row.cpha ? cur_row.cpol : ~cur_row.cpol))) begin
                mon_bits = {mon_bits[DW-2:0], prev_mosi};
                mon_cnt  = mon_cnt + 1'b1;
            end
        end
        prev_on     = mon_on;
        prev_sclk   = sclk;
        prev_mosi   = mosi;
        prev_cs_low = cs_n != '1;
    end

    initial begin
        spi_reg_pkg::spi_reg_word_u word;
        spi_reg_pkg::spi_reg_word_u exp_word;
        spi_reg_pkg::status_t       exp_status;
        logic [DW-1:0]              burst [BURST];
        aw      = '0;
        w_ch    = '0;
        ar      = '0;
        b_ready = 1'b0;
        r_ready = 1'b0;
        for (int i = 0; i < ROWS; i++) begin
            stim_table[i].tx = DW'($random(seed));
        end
        @(posedge arst_n);

        // reset state, parameters and plain read back.
        exp_status          = '0;
        exp_status.rx_empty = 1'b1;
        exp_status.tx_empty = 1'b1;
        bus_read(spi_reg_pkg::STATUS_REG, word);
        check_status("status after reset", word.status, exp_status);
        exp_word.raw              = '0;
        exp_word.param.data_width = 8'd8;
        exp_word.param.fifo_depth = 16'(FIFO_DEPTH);
        exp_word.param.reg_num    = 8'd8;
        bus_read(spi_reg_pkg::PARAM_REG, word);
        check_word("param", word, exp_word);
        bus_write(spi_reg_pkg::DIVIDER_REG, 32'h0000_005a);
        bus_read(spi_reg_pkg::DIVIDER_REG, word);
        exp_word.raw = 32'h0000_005a;
        check_word("divider", word, exp_word);
        bus_write(spi_reg_pkg::WAIT_REG, 32'h0000_00c3);
        bus_read(spi_reg_pkg::WAIT_REG, word);
        exp_word.raw = 32'h0000_00c3;
        check_word("wait", word, exp_word);

        for (int i = 0; i < ROWS; i++) begin
            set_mode(stim_table[i]);
            @(posedge clk);
            cur_row = stim_table[i];
            mon_on  = 1'b1;
            bus_write(spi_reg_pkg::TX_DATA_REG, {24'd0, stim_table[i].tx});
            bus_read(spi_reg_pkg::STATUS_REG, word);
            while (word.status.rx_empty) bus_read(spi_reg_pkg::STATUS_REG, word);
            bus_read(spi_reg_pkg::RX_DATA_REG, word);
            check_byte("rx_data", word.lo.data, stim_table[i].tx);
            @(posedge clk);
            mon_on = 1'b0;
            check_byte("mosi_o bit count", mon_cnt, 8'd8);
            check_byte("mosi_o bits", mon_bits, stim_table[i].tx);
        end

        // burst into a 4 deep fifo, byte 6 is dropped.
        set_mode(stim_row_t'{1'b0, 1'b0, 8'(BIG_DIV), 8'd0, 8'd0, 8'h00});
        for (int i = 0; i < BURST; i++) begin
            burst[i] = DW'($random(seed));
            bus_write(spi_reg_pkg::TX_DATA_REG, {24'd0, burst[i]});
        end
        exp_status          = '0;
        exp_status.rx_empty = 1'b1;
        exp_status.tx_full  = 1'b1;
        bus_read(spi_reg_pkg::STATUS_REG, word);
        check_status("status after burst", word.status, exp_status);
        bus_read(spi_reg_pkg::STATUS_REG, word);
        while (!word.status.rx_full) bus_read(spi_reg_pkg::STATUS_REG, word);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            bus_read(spi_reg_pkg::RX_DATA_REG, word);
            check_byte("rx_data burst", word.lo.data, burst[i]);
        end
        // fifth byte goes out once there is room and stays in the rx fifo.
        bus_read(spi_reg_pkg::STATUS_REG, word);
        while (word.status.rx_empty) bus_read(spi_reg_pkg::STATUS_REG, word);

        // soft reset with a byte received, one in flight and one queued.
        bus_write(spi_reg_pkg::TX_DATA_REG, 32'h0000_0011);
        bus_write(spi_reg_pkg::TX_DATA_REG, 32'h0000_0022);
        bus_write(spi_reg_pkg::CONTROL_REG, 32'h0000_0001);
        bus_write(spi_reg_pkg::CONTROL_REG, 32'h0000_0000);
        exp_status          = '0;
        exp_status.rx_empty = 1'b1;
        exp_status.tx_empty = 1'b1;
        bus_read(spi_reg_pkg::STATUS_REG, word);
        check_status("status after soft reset", word.status, exp_status);
        check_select("cs_n_o after soft reset", cs_n, '1);
        check_pin("sclk_o after soft reset", sclk, 1'b0);
        bus_read(spi_reg_pkg::RX_DATA_REG, word);
        check_byte("rx_data when empty", word.lo.data, 8'h00);

        if (err_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

/* files.f */
source/spi_bus_pkg.sv
source/spi_reg_pkg.sv
source/spi_byte_fifo.sv
source/spi_shift_engine.sv
source/axil_spi_regs.sv
source/axil_spi.sv
tb/tb_clock_gen.sv
tb/axil_spi_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = axil_spi_tb
FILELIST = files.f
OBJ_DIR  = obj_dir
EXE      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE)

clean:
	rm -rf $(OBJ_DIR)
